//--- logic/a2_shadow_defs.svh
// Assumes a 16-bit Apple II bus address, 8-bit data and 32-bit video RAM words
`ifndef A2_SHADOW_DEFS_SVH
`define A2_SHADOW_DEFS_SVH

// Bus and RAM widths
`define A2_ADDR_W        16
`define A2_DATA_W        8
`define VRAM_WORD_W      32
`define TEXT_RAM_AW      10
`define HIRES_RAM_AW     12

// Soft-switch pages, compared against addr[15:4]
`define A2_SW_II_PAGE    12'hC05
`define A2_SW_IIE_PAGE   12'hC00

// Keyboard
`define A2_KBD_ADDR      16'hC000
`define A2_KBDSTRB_ADDR  16'hC010

// Colour, mono and SHR registers
`define A2_COLOR_ADDR    16'hC022
`define A2_BORDER_ADDR   16'hC034
`define A2_MONO_ADDR     16'hC021
`define A2_NEWVIDEO_ADDR 16'hC029

`endif

//--- logic/a2_shadow_pkg.sv
// Window checks cover the page-1 and page-2 ranges only; no 6000-9FFF aux extension
`include "a2_shadow_defs.svh"

package a2_shadow_pkg;

    // 0400-0BFF, text pages 1 and 2
    function automatic logic in_text_window(input logic [`A2_ADDR_W-1:0] addr);
        return addr[15:10] inside {6'b000001, 6'b000010};
    endfunction

    // 2000-5FFF, hires pages 1 and 2
    function automatic logic in_hires_window(input logic [`A2_ADDR_W-1:0] addr);
        return addr[15:13] inside {3'b001, 3'b010};
    endfunction

    function automatic logic [3:0] byte_lane_enable(input logic [1:0] lane);
        return 4'b0001 << lane;
    endfunction

    // Aux byte sits above its main byte, as the scanner expects
    function automatic logic [`VRAM_WORD_W-1:0] interleave_bytes(
        input logic                    hi,
        input logic [`VRAM_WORD_W-1:0] main_word,
        input logic [`VRAM_WORD_W-1:0] aux_word
    );
        if (hi) begin
            return {aux_word[31:24], main_word[31:24], aux_word[23:16], main_word[23:16]};
        end
        return {aux_word[15:8], main_word[15:8], aux_word[7:0], main_word[7:0]};
    endfunction

endpackage

//--- logic/a2_bus_intf.sv
// One clock domain; strobes are single-cycle pulses already aligned to clk
`include "a2_shadow_defs.svh"

interface a2_bus_intf;
    logic                   clk;
    logic                   rst_n;
    logic [`A2_ADDR_W-1:0]  addr;
    logic [`A2_DATA_W-1:0]  data;
    logic                   rw_n;
    logic                   data_in_strobe;
    logic                   phi1_posedge;
    // Slot select and aux bank hint from the card edge
    logic                   m2sel_n;
    logic                   m2b0;

    modport sink (
        input clk,
        input rst_n,
        input addr,
        input data,
        input rw_n,
        input data_in_strobe,
        input phi1_posedge,
        input m2sel_n,
        input m2b0
    );

endinterface

//--- logic/sdpram32.sv
// Read data is registered and returns the old word on a same-address write
`include "a2_shadow_defs.svh"

module sdpram32 #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                      clk_i,
    input  logic [ADDR_WIDTH-1:0]     wr_addr_i,
    input  logic [`VRAM_WORD_W-1:0]   wr_data_i,
    input  logic                      wr_en_i,
    input  logic [3:0]                byte_en_i,
    input  logic [ADDR_WIDTH-1:0]     rd_addr_i,
    output logic [`VRAM_WORD_W-1:0]   rd_data_o
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [`VRAM_WORD_W/8-1:0][7:0] mem [DEPTH];

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            // Byte-masked write, one lane per bus byte
            for (int b = 0; b < `VRAM_WORD_W / 8; b++) begin
                if (byte_en_i[b]) begin
                    mem[wr_addr_i][b] <= wr_data_i[b*8 +: 8];
                end
            end
        end
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

//--- logic/softswitch_regs.sv
// IIe aux rule covers ALTZP, STORE80, PAGE2, HIRES and RAMWRT; reads are never shadowed
`include "a2_shadow_defs.svh"

module softswitch_regs (
    a2_bus_intf.sink   bus,
    output logic       aux_bank_o,
    output logic [7:0] sw_ii_o,
    output logic [7:0] sw_iie_o,
    output logic [3:0] background_color_o,
    output logic [3:0] text_color_o,
    output logic [3:0] border_color_o,
    output logic       monochrome_o,
    output logic       dhires_mono_o,
    output logic       linearize_o,
    output logic       shrg_mode_o,
    output logic [7:0] keycode_o,
    output logic       keypress_strobe_o
);

    logic write_strobe;
    logic read_strobe;
    logic sw_access;
    logic aux_mem;

    assign write_strobe = !bus.rw_n && bus.data_in_strobe;
    assign read_strobe  = bus.rw_n && bus.data_in_strobe;
    assign sw_access    = bus.phi1_posedge && !bus.m2sel_n;

    // Address bits 3:1 pick the switch, bit 0 is its new state
    always_ff @(posedge bus.clk) begin
        if (!bus.rst_n) begin
            sw_ii_o  <= 8'h83;
            sw_iie_o <= 8'h00;
        end else begin
            if (sw_access && bus.addr[15:4] == `A2_SW_II_PAGE) begin
                sw_ii_o[bus.addr[3:1]] <= bus.addr[0];
            end
            // IIe switches respond to writes only
            if (sw_access && !bus.rw_n && bus.addr[15:4] == `A2_SW_IIE_PAGE) begin
                sw_iie_o[bus.addr[3:1]] <= bus.addr[0];
            end
        end
    end

    always_ff @(posedge bus.clk) begin
        if (!bus.rst_n) begin
            background_color_o <= 4'h0;
            text_color_o       <= 4'hF;
            border_color_o     <= 4'h0;
            monochrome_o       <= 1'b0;
            dhires_mono_o      <= 1'b0;
            linearize_o        <= 1'b0;
            shrg_mode_o        <= 1'b0;
        end else if (write_strobe) begin
            if (bus.addr == `A2_COLOR_ADDR) begin
                background_color_o <= bus.data[3:0];
                text_color_o       <= bus.data[7:4];
            end
            if (bus.addr == `A2_BORDER_ADDR) begin
                border_color_o <= bus.data[3:0];
            end
            if (bus.addr == `A2_MONO_ADDR) begin
                monochrome_o <= bus.data[7];
            end
            // NEWVIDEO register
            if (bus.addr == `A2_NEWVIDEO_ADDR) begin
                dhires_mono_o <= bus.data[5];
                linearize_o   <= bus.data[6] | bus.data[7];
                shrg_mode_o   <= bus.data[7];
            end
        end
    end

    // Keyboard latch, bit 7 is the key-ready flag
    always_ff @(posedge bus.clk) begin
        if (!bus.rst_n) begin
            keycode_o         <= 8'h00;
            keypress_strobe_o <= 1'b0;
        end else begin
            keypress_strobe_o <= 1'b0;
            if (read_strobe && bus.addr == `A2_KBD_ADDR) begin
                if (bus.data[7] && !keycode_o[7]) begin
                    keycode_o         <= bus.data;
                    keypress_strobe_o <= 1'b1;
                end
            end else if (bus.data_in_strobe && bus.addr == `A2_KBDSTRB_ADDR) begin
                keycode_o[7] <= 1'b0;
            end
        end
    end

    // STORE80 = iie[0], RAMWRT = iie[2], ALTZP = iie[4], PAGE2 = ii[2], HIRES = ii[3]
    always_comb begin
        if (bus.addr[15:9] == 7'b0000000 || bus.addr[15:14] == 2'b11) begin
            aux_mem = sw_iie_o[4];
        end else if (bus.addr[15:10] == 6'b000001) begin
            aux_mem = sw_iie_o[0] ? sw_ii_o[2] : (sw_iie_o[2] && !bus.rw_n);
        end else if (bus.addr[15:13] == 3'b001) begin
            aux_mem = (sw_iie_o[0] && sw_ii_o[3]) ? sw_ii_o[2] : (sw_iie_o[2] && !bus.rw_n);
        end else begin
            aux_mem = sw_iie_o[2] && !bus.rw_n;
        end
    end

    assign aux_bank_o = aux_mem || bus.m2b0;

endmodule

//--- logic/text_shadow.sv
// Text window 0400-0BFF only; main and aux bytes alternate within each RAM word
`include "a2_shadow_defs.svh"

module text_shadow
    import a2_shadow_pkg::*;
(
    a2_bus_intf.sink                 bus,
    input  logic                     aux_bank_i,
    input  logic [`A2_ADDR_W-1:0]    video_address_i,
    output logic [`VRAM_WORD_W-1:0]  text_word_o
);

    logic                       wr_en;
    logic [`TEXT_RAM_AW+1:0]    wr_offset;
    logic [`TEXT_RAM_AW-1:0]    rd_addr;

    assign wr_en = !bus.rw_n && bus.data_in_strobe && in_text_window(bus.addr);

    // Page 2 folds onto the upper half, aux bank is the lowest index bit
    assign wr_offset = {!bus.addr[10], bus.addr[9:0], aux_bank_i};

    // Each word holds two bus addresses, main and aux
    assign rd_addr = {!video_address_i[10], video_address_i[9:1]};

    sdpram32 #(
        .ADDR_WIDTH(`TEXT_RAM_AW)
    ) text_ram_i (
        .clk_i     (bus.clk),
        .wr_addr_i (wr_offset[`TEXT_RAM_AW+1:2]),
        .wr_data_i ({4{bus.data}}),
        .wr_en_i   (wr_en),
        .byte_en_i (byte_lane_enable(wr_offset[1:0])),
        .rd_addr_i (rd_addr),
        .rd_data_o (text_word_o)
    );

endmodule

//--- logic/hires_shadow.sv
// Hires window 2000-5FFF only; 16 KB each of main and aux, no VGC extension
`include "a2_shadow_defs.svh"

module hires_shadow
    import a2_shadow_pkg::*;
(
    a2_bus_intf.sink                 bus,
    input  logic                     aux_bank_i,
    input  logic [`A2_ADDR_W-1:0]    video_address_i,
    output logic [`VRAM_WORD_W-1:0]  hires_main_word_o,
    output logic [`VRAM_WORD_W-1:0]  hires_aux_word_o
);

    logic                       hires_write;
    logic [`HIRES_RAM_AW+1:0]   wr_offset;
    logic [3:0]                 byte_en;
    logic [`HIRES_RAM_AW-1:0]   rd_addr;

    assign hires_write = !bus.rw_n && bus.data_in_strobe && in_hires_window(bus.addr);

    // Byte offset from 2000
    assign wr_offset = bus.addr[`HIRES_RAM_AW+1:0] - 14'h2000;
    assign byte_en   = byte_lane_enable(wr_offset[1:0]);

    assign rd_addr = {!video_address_i[13], video_address_i[12:2]};

    sdpram32 #(
        .ADDR_WIDTH(`HIRES_RAM_AW)
    ) main_ram_i (
        .clk_i     (bus.clk),
        .wr_addr_i (wr_offset[`HIRES_RAM_AW+1:2]),
        .wr_data_i ({4{bus.data}}),
        .wr_en_i   (hires_write && !aux_bank_i),
        .byte_en_i (byte_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (hires_main_word_o)
    );

    // Aux bank, same layout as main
    sdpram32 #(
        .ADDR_WIDTH(`HIRES_RAM_AW)
    ) aux_ram_i (
        .clk_i     (bus.clk),
        .wr_addr_i (wr_offset[`HIRES_RAM_AW+1:2]),
        .wr_data_i ({4{bus.data}}),
        .wr_en_i   (hires_write && aux_bank_i),
        .byte_en_i (byte_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (hires_aux_word_o)
    );

endmodule

//--- logic/video_combiner.sv
// One-cycle read latency; addresses outside the text and hires windows read as zero
`include "a2_shadow_defs.svh"

module video_combiner
    import a2_shadow_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic [`A2_ADDR_W-1:0]    video_address_i,
    input  logic [`VRAM_WORD_W-1:0]  text_word_i,
    input  logic [`VRAM_WORD_W-1:0]  hires_main_word_i,
    input  logic [`VRAM_WORD_W-1:0]  hires_aux_word_i,
    output logic [`VRAM_WORD_W-1:0]  video_data_o
);

    logic text_hit_q;
    logic hires_hit_q;
    logic addr_bit1_q;

    // Decode tracks the RAM read register
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            text_hit_q  <= 1'b0;
            hires_hit_q <= 1'b0;
            addr_bit1_q <= 1'b0;
        end else begin
            text_hit_q  <= in_text_window(video_address_i);
            hires_hit_q <= in_hires_window(video_address_i);
            addr_bit1_q <= video_address_i[1];
        end
    end

    always_comb begin
        if (text_hit_q) begin
            video_data_o = text_word_i;
        end else if (hires_hit_q) begin
            // Bit 1 picks the upper or lower byte pair
            video_data_o = interleave_bytes(addr_bit1_q, hires_main_word_i, hires_aux_word_i);
        end else begin
            video_data_o = '0;
        end
    end

endmodule

//--- logic/apple_shadow_top.sv
// Single clock a2bus_if with synchronous active-low reset; bus and scanner never stall
`include "a2_shadow_defs.svh"

module apple_shadow_top (
    input  logic                     a2bus_if,
    input  logic                     rst_n_i,
    input  logic [`A2_ADDR_W-1:0]    addr_i,
    input  logic [`A2_DATA_W-1:0]    data_i,
    input  logic                     rw_n_i,
    input  logic                     data_in_strobe_i,
    input  logic                     phi1_posedge_i,
    input  logic                     m2sel_n_i,
    input  logic                     m2b0_i,
    input  logic [`A2_ADDR_W-1:0]    video_address_i,
    output logic [`VRAM_WORD_W-1:0]  video_data_o,
    output logic [7:0]               sw_ii_o,
    output logic [7:0]               sw_iie_o,
    output logic [3:0]               background_color_o,
    output logic [3:0]               text_color_o,
    output logic [3:0]               border_color_o,
    output logic                     monochrome_o,
    output logic                     dhires_mono_o,
    output logic                     linearize_o,
    output logic                     shrg_mode_o,
    output logic [7:0]               keycode_o,
    output logic                     keypress_strobe_o
);

    logic                       aux_bank;
    logic [`VRAM_WORD_W-1:0]    text_word;
    logic [`VRAM_WORD_W-1:0]    hires_main_word;
    logic [`VRAM_WORD_W-1:0]    hires_aux_word;

    a2_bus_intf bus ();

    assign bus.clk            = a2bus_if;
    assign bus.rst_n          = rst_n_i;
    assign bus.addr           = addr_i;
    assign bus.data           = data_i;
    assign bus.rw_n           = rw_n_i;
    assign bus.data_in_strobe = data_in_strobe_i;
    assign bus.phi1_posedge   = phi1_posedge_i;
    assign bus.m2sel_n        = m2sel_n_i;
    assign bus.m2b0           = m2b0_i;

    softswitch_regs softswitch_regs_i (
        .bus                (bus),
        .aux_bank_o         (aux_bank),
        .sw_ii_o            (sw_ii_o),
        .sw_iie_o           (sw_iie_o),
        .background_color_o (background_color_o),
        .text_color_o       (text_color_o),
        .border_color_o     (border_color_o),
        .monochrome_o       (monochrome_o),
        .dhires_mono_o      (dhires_mono_o),
        .linearize_o        (linearize_o),
        .shrg_mode_o        (shrg_mode_o),
        .keycode_o          (keycode_o),
        .keypress_strobe_o  (keypress_strobe_o)
    );

    text_shadow text_shadow_i (
        .bus             (bus),
        .aux_bank_i      (aux_bank),
        .video_address_i (video_address_i),
        .text_word_o     (text_word)
    );

    hires_shadow hires_shadow_i (
        .bus               (bus),
        .aux_bank_i        (aux_bank),
        .video_address_i   (video_address_i),
        .hires_main_word_o (hires_main_word),
        .hires_aux_word_o  (hires_aux_word)
    );

    video_combiner video_combiner_i (
        .clk_i             (a2bus_if),
        .rst_n_i           (rst_n_i),
        .video_address_i   (video_address_i),
        .text_word_i       (text_word),
        .hires_main_word_i (hires_main_word),
        .hires_aux_word_i  (hires_aux_word),
        .video_data_o      (video_data_o)
    );

endmodule

//--- dv/tb_apple_shadow.sv
// Fills every shadowed byte in both banks before random scanner reads; about 43k bus cycles
`include "a2_shadow_defs.svh"

module tb_apple_shadow;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 10;
    localparam int FILL_TXNS     = 2 * (16'h0800 + 16'h4000);
    localparam int RANDOM_TXNS   = 6000;
    localparam int PLANNED_TXNS  = RESET_CYCLES + 10 + FILL_TXNS + RANDOM_TXNS;
    localparam int WATCHDOG_TIME = (RESET_CYCLES + 20 * PLANNED_TXNS) * CLK_PERIOD;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        hold_reset = 1'b1;
    logic [15:0] bus_addr;
    logic [7:0]  bus_data;
    logic        rw_n;
    logic        data_in_strobe;
    logic        phi1_posedge;
    logic        m2sel_n;
    logic        m2b0;
    logic [15:0] video_address;
    integer      seed = 32'hb3f5_3015;

    logic [31:0] video_data;
    logic [7:0]  sw_ii;
    logic [7:0]  sw_iie;
    logic [3:0]  background_color;
    logic [3:0]  text_color;
    logic [3:0]  border_color;
    logic        monochrome;
    logic        dhires_mono;
    logic        linearize;
    logic        shrg_mode;
    logic [7:0]  keycode;
    logic        keypress_strobe;

    // Reference model state
    logic [7:0]  main_mem [65536];
    logic [7:0]  aux_mem [65536];
    logic [7:0]  m_sw_ii;
    logic [7:0]  m_sw_iie;
    logic [3:0]  m_bg;
    logic [3:0]  m_text;
    logic [3:0]  m_border;
    logic        m_mono;
    logic        m_dhires;
    logic        m_linear;
    logic        m_shrg;
    logic [7:0]  m_key;
    logic        m_kp;
    logic [31:0] exp_video;

    apple_shadow_top dut_i (
        .a2bus_if           (clk),
        .rst_n_i            (rst_n),
        .addr_i             (bus_addr),
        .data_i             (bus_data),
        .rw_n_i             (rw_n),
        .data_in_strobe_i   (data_in_strobe),
        .phi1_posedge_i     (phi1_posedge),
        .m2sel_n_i          (m2sel_n),
        .m2b0_i             (m2b0),
        .video_address_i    (video_address),
        .video_data_o       (video_data),
        .sw_ii_o            (sw_ii),
        .sw_iie_o           (sw_iie),
        .background_color_o (background_color),
        .text_color_o       (text_color),
        .border_color_o     (border_color),
        .monochrome_o       (monochrome),
        .dhires_mono_o      (dhires_mono),
        .linearize_o        (linearize),
        .shrg_mode_o        (shrg_mode),
        .keycode_o          (keycode),
        .keypress_strobe_o  (keypress_strobe)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_failure();
        $display("Errors found");
        $fatal(1, "Stopping at first failure");
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_nibble(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            report_failure();
        end
    endtask

    function automatic logic is_shadowed(input logic [15:0] a);
        return (a >= 16'h0400 && a < 16'h0C00) || (a >= 16'h2000 && a < 16'h6000);
    endfunction

    // STORE80 redirects page 1 to PAGE2 and RAMWRT decides the rest
    function automatic logic model_aux_bank(input logic [15:0] a, input logic b0);
        logic aux;
        aux = m_sw_iie[2];
        if (a >= 16'h0400 && a < 16'h0800 && m_sw_iie[0]) begin
            aux = m_sw_ii[2];
        end
        if (a >= 16'h2000 && a < 16'h4000 && m_sw_iie[0] && m_sw_ii[3]) begin
            aux = m_sw_ii[2];
        end
        return aux || b0;
    endfunction

    // Scanner word is main/aux byte pairs starting at the even address
    function automatic logic [31:0] expected_video(input logic [15:0] va);
        logic [15:0] b;
        b = {va[15:1], 1'b0};
        if (!is_shadowed(va)) begin
            return 32'h0;
        end
        return {aux_mem[b + 1], main_mem[b + 1], aux_mem[b], main_mem[b]};
    endfunction

    // Applies the transaction that the DUT samples at this edge
    task automatic apply_model();
        logic wr;
        wr   = !rw_n && data_in_strobe;
        m_kp = 1'b0;
        if (!rst_n) begin
            m_sw_ii   = 8'h83;
            m_sw_iie  = 8'h00;
            m_bg      = 4'h0;
            m_text    = 4'hF;
            m_border  = 4'h0;
            m_mono    = 1'b0;
            m_dhires  = 1'b0;
            m_linear  = 1'b0;
            m_shrg    = 1'b0;
            m_key     = 8'h00;
            exp_video = 32'h0;
        end else begin
            exp_video = expected_video(video_address);
            if (wr && is_shadowed(bus_addr)) begin
                if (model_aux_bank(bus_addr, m2b0)) begin
                    aux_mem[bus_addr] = bus_data;
                end else begin
                    main_mem[bus_addr] = bus_data;
                end
            end
            if (wr && bus_addr == `A2_COLOR_ADDR) begin
                m_bg   = bus_data[3:0];
                m_text = bus_data[7:4];
            end
            if (wr && bus_addr == `A2_BORDER_ADDR) begin
                m_border = bus_data[3:0];
            end
            if (wr && bus_addr == `A2_MONO_ADDR) begin
                m_mono = bus_data[7];
            end
            if (wr && bus_addr == `A2_NEWVIDEO_ADDR) begin
                m_dhires = bus_data[5];
                m_linear = bus_data[6] || bus_data[7];
                m_shrg   = bus_data[7];
            end
            if (data_in_strobe && rw_n && bus_addr == `A2_KBD_ADDR
                    && bus_data[7] && !m_key[7]) begin
                m_key = bus_data;
                m_kp  = 1'b1;
            end
            if (data_in_strobe && bus_addr == `A2_KBDSTRB_ADDR) begin
                m_key[7] = 1'b0;
            end
            if (phi1_posedge && !m2sel_n && bus_addr[15:4] == `A2_SW_II_PAGE) begin
                m_sw_ii[bus_addr[3:1]] = bus_addr[0];
            end
            if (phi1_posedge && !m2sel_n && !rw_n && bus_addr[15:4] == `A2_SW_IIE_PAGE) begin
                m_sw_iie[bus_addr[3:1]] = bus_addr[0];
            end
        end
    endtask

    task automatic compare_outputs();
        check_word("video_data_o", video_data, exp_video);
        check_byte("sw_ii_o", sw_ii, m_sw_ii);
        check_byte("sw_iie_o", sw_iie, m_sw_iie);
        check_nibble("background_color_o", background_color, m_bg);
        check_nibble("text_color_o", text_color, m_text);
        check_nibble("border_color_o", border_color, m_border);
        check_bit("monochrome_o", monochrome, m_mono);
        check_bit("dhires_mono_o", dhires_mono, m_dhires);
        check_bit("linearize_o", linearize, m_linear);
        check_bit("shrg_mode_o", shrg_mode, m_shrg);
        check_byte("keycode_o", keycode, m_key);
        check_bit("keypress_strobe_o", keypress_strobe, m_kp);
    endtask

    // One bus cycle, driven at the rising edge and checked at the falling edge
    task automatic step(
        input logic [15:0] a,
        input logic [7:0]  d,
        input logic        rw,
        input logic        strobe,
        input logic        phi1,
        input logic        sel_n,
        input logic        b0,
        input logic [15:0] va
    );
        @(posedge clk);
        apply_model();
        rst_n          <= !hold_reset;
        bus_addr       <= a;
        bus_data       <= d;
        rw_n           <= rw;
        data_in_strobe <= strobe;
        phi1_posedge   <= phi1;
        m2sel_n        <= sel_n;
        m2b0           <= b0;
        video_address  <= va;
        @(negedge clk);
        compare_outputs();
    endtask

    task automatic idle_step();
        step(16'h0000, 8'h00, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 16'h0000);
    endtask

    task automatic keyboard_read(input logic [15:0] a, input logic [7:0] d);
        step(a, d, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 16'h0000);
    endtask

    // Switches are at reset here, so m2b0 alone picks the bank
    task automatic fill_memories();
        for (int bank = 0; bank < 2; bank++) begin
            for (int i = 0; i < 65536; i++) begin
                if (is_shadowed(i[15:0])) begin
                    step(i[15:0], $random(seed), 1'b0, 1'b1, 1'b0, 1'b1, bank[0], 16'h0000);
                end
            end
        end
    endtask

    task automatic random_txn();
        logic [31:0] r;
        logic [31:0] rv;
        logic [15:0] a;
        logic [7:0]  d;
        logic        rw;
        logic        strobe;
        logic        phi1;
        logic        sel_n;
        logic        b0;
        logic [15:0] va;
        r      = $random(seed);
        rv     = $random(seed);
        a      = $random(seed);
        d      = $random(seed);
        rw     = r[4];
        strobe = 1'b0;
        phi1   = 1'b0;
        sel_n  = 1'b1;
        b0     = 1'b0;
        case (r[2:0])
            3'd0, 3'd1: begin
                a      = 16'h0400 + {5'b0, a[10:0]};
                rw     = 1'b0;
                strobe = 1'b1;
                b0     = (r[6:5] == 2'b00);
            end
            3'd2, 3'd3: begin
                a      = 16'h2000 + {2'b0, a[13:0]};
                rw     = 1'b0;
                strobe = 1'b1;
                b0     = (r[6:5] == 2'b00);
            end
            3'd4: begin
                a[15:4] = r[5] ? `A2_SW_II_PAGE : `A2_SW_IIE_PAGE;
                phi1    = 1'b1;
                sel_n   = (r[7:6] == 2'b00);
            end
            3'd5: begin
                case (r[6:5])
                    2'd0: a = `A2_COLOR_ADDR;
                    2'd1: a = `A2_BORDER_ADDR;
                    2'd2: a = `A2_MONO_ADDR;
                    default: a = `A2_NEWVIDEO_ADDR;
                endcase
                rw     = 1'b0;
                strobe = 1'b1;
            end
            3'd6: begin
                strobe = 1'b1;
                a      = (r[6:5] == 2'b00) ? `A2_KBDSTRB_ADDR : `A2_KBD_ADDR;
                rw     = (a == `A2_KBD_ADDR) ? 1'b1 : r[7];
            end
            default: begin
            end
        endcase
        case (rv[1:0])
            2'd0: va = 16'h0400 + {5'b0, rv[12:2]};
            2'd1: va = 16'h2000 + {2'b0, rv[15:2]};
            2'd2: va = rv[31:16];
            // Just inside or just outside a window boundary
            default: begin
                case (rv[3:2])
                    2'd0: va = 16'h0400 - {15'b0, rv[4]};
                    2'd1: va = 16'h0C00 - {15'b0, rv[4]};
                    2'd2: va = 16'h2000 - {15'b0, rv[4]};
                    default: va = 16'h6000 - {15'b0, rv[4]};
                endcase
            end
        endcase
        step(a, d, rw, strobe, phi1, sel_n, b0, va);
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the run did not finish within the expected number of cycles");
        report_failure();
    end

    initial begin
        bus_addr       = 16'h0000;
        bus_data       = 8'h00;
        rw_n           = 1'b1;
        data_in_strobe = 1'b0;
        phi1_posedge   = 1'b0;
        m2sel_n        = 1'b1;
        m2b0           = 1'b0;
        video_address  = 16'h0000;
        // The first edge already samples the initial low reset
        repeat (RESET_CYCLES - 1) idle_step();
        hold_reset = 1'b0;
        idle_step();
        idle_step();
        // Reset values straight from the register map
        check_byte("sw_ii_o", sw_ii, 8'h83);
        check_byte("sw_iie_o", sw_iie, 8'h00);
        check_nibble("background_color_o", background_color, 4'h0);
        check_nibble("text_color_o", text_color, 4'hF);
        check_nibble("border_color_o", border_color, 4'h0);
        check_bit("monochrome_o", monochrome, 1'b0);
        check_bit("dhires_mono_o", dhires_mono, 1'b0);
        check_bit("linearize_o", linearize, 1'b0);
        check_bit("shrg_mode_o", shrg_mode, 1'b0);
        check_bit("keypress_strobe_o", keypress_strobe, 1'b0);
        // Second key before the strobe clear must be ignored
        keyboard_read(`A2_KBD_ADDR, 8'hC1);
        keyboard_read(`A2_KBD_ADDR, 8'hC2);
        keyboard_read(`A2_KBDSTRB_ADDR, 8'h00);
        keyboard_read(`A2_KBD_ADDR, 8'hC3);
        idle_step();
        check_byte("keycode_o", keycode, 8'hC3);
        fill_memories();
        repeat (RANDOM_TXNS) random_txn();
        idle_step();
        $display("No errors");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+logic
logic/a2_shadow_pkg.sv
logic/a2_bus_intf.sv
logic/sdpram32.sv
logic/softswitch_regs.sv
logic/text_shadow.sv
logic/hires_shadow.sv
logic/video_combiner.sv
logic/apple_shadow_top.sv
dv/tb_apple_shadow.sv
